// ==== filelist.f ====
+incdir+rtl
rtl/proc_pkg.sv
rtl/proc_regfile.sv
rtl/proc_decode.sv
rtl/proc_execute.sv
rtl/proc_result.sv
rtl/proc_ctrl.sv
rtl/proc_top.sv
test/proc_tb_clk.sv
test/proc_tb.sv

// ==== rtl/proc_ctrl.sv ====
// Pipeline control: opcode decode, X/W flag tracking, bypass select,
// MFX stall and the freeze on manager output back-pressure
`include "proc_params.svh"

module proc_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [31:0]              inst_d,
  input  logic                     inst_val,
  output logic                     inst_rdy,
  input  logic                     mngr_in_val,
  output logic                     mngr_in_rdy,
  input  logic                     mngr_out_rdy,
  output logic                     mngr_out_val,
  output logic                     en_d,
  output logic                     en_x,
  output logic                     en_w,
  output logic                     bubble_x,
  output logic [1:0]               byp0_sel,
  output logic [1:0]               byp1_sel,
  output logic                     op1_imm,
  output proc_pkg::alu_fn_e        alu_fn_x,
  output logic                     wen_w,
  output logic [`PROC_RADDR_W-1:0] waddr_w
);

  import proc_pkg::*;

  logic                     val_d;
  opcode_e                  opcode_d;
  logic [`PROC_RADDR_W-1:0] rd_d;
  logic [`PROC_RADDR_W-1:0] rs_d;
  logic [`PROC_RADDR_W-1:0] rt_d;
  logic                     wen_d;
  logic                     mtx_d;
  logic                     mfx_d;
  alu_fn_e                  alu_fn_d;
  logic                     wen_x;
  logic                     mtx_x;
  logic [`PROC_RADDR_W-1:0] waddr_x;
  logic                     mtx_w;
  logic                     freeze;
  logic                     stall_mfx;

  // -------------------------------------------------------------------------
  // D stage decode
  // -------------------------------------------------------------------------

  // An empty D slot decodes as NOP
  assign opcode_d = val_d ? opcode_e'(inst_d[31:28]) : OP_NOP;
  assign rd_d     = inst_d[27:25];
  assign rs_d     = inst_d[24:22];
  assign rt_d     = inst_d[21:19];

  always_comb begin
    wen_d    = 1'b0;
    mtx_d    = 1'b0;
    mfx_d    = 1'b0;
    op1_imm  = 1'b0;
    alu_fn_d = ALU_CP1;
    case (opcode_d)
      OP_ADD: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_ADD;
      end
      OP_SUB: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_SUB;
      end
      OP_AND: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_AND;
      end
      OP_OR: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_OR;
      end
      OP_XOR: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_XOR;
      end
      OP_SLT: begin
        wen_d    = 1'b1;
        alu_fn_d = ALU_SLT;
      end
      OP_ADDI: begin
        wen_d    = 1'b1;
        op1_imm  = 1'b1;
        alu_fn_d = ALU_ADD;
      end
      OP_MFX: begin
        wen_d = 1'b1;
        mfx_d = 1'b1;
      end
      OP_MTX: begin
        mtx_d = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // Stalls and stage enables
  // -------------------------------------------------------------------------

  // Whole pipeline holds while W waits to hand off an MTX value
  assign freeze    = mtx_w & ~mngr_out_rdy;
  assign stall_mfx = mfx_d & ~mngr_in_val;

  assign en_x     = ~freeze;
  assign en_w     = ~freeze;
  assign inst_rdy = ~freeze & ~stall_mfx;
  assign en_d     = inst_val & inst_rdy;
  assign bubble_x = stall_mfx;

  assign mngr_in_rdy  = mfx_d & ~freeze;
  assign mngr_out_val = mtx_w;

  // -------------------------------------------------------------------------
  // Bypass selection, nearest stage wins
  // -------------------------------------------------------------------------

  always_comb begin
    if (wen_x && waddr_x == rs_d) begin
      byp0_sel = BYP_X;
    end else if (wen_w && waddr_w == rs_d) begin
      byp0_sel = BYP_W;
    end else begin
      byp0_sel = BYP_RF;
    end
    if (wen_x && waddr_x == rt_d) begin
      byp1_sel = BYP_X;
    end else if (wen_w && waddr_w == rt_d) begin
      byp1_sel = BYP_W;
    end else begin
      byp1_sel = BYP_RF;
    end
  end

  // -------------------------------------------------------------------------
  // Per-stage control registers
  // -------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      val_d    <= 1'b0;
      wen_x    <= 1'b0;
      mtx_x    <= 1'b0;
      waddr_x  <= '0;
      alu_fn_x <= ALU_CP1;
      wen_w    <= 1'b0;
      mtx_w    <= 1'b0;
      waddr_w  <= '0;
    end else begin
      if (inst_rdy) begin
        val_d <= inst_val;
      end
      // Squashed slot keeps its fields but loses its side effects
      if (en_x) begin
        wen_x    <= wen_d & ~bubble_x;
        mtx_x    <= mtx_d & ~bubble_x;
        waddr_x  <= rd_d;
        alu_fn_x <= alu_fn_d;
      end
      if (en_w) begin
        wen_w   <= wen_x;
        mtx_w   <= mtx_x;
        waddr_w <= waddr_x;
      end
    end
  end

endmodule

// ==== rtl/proc_decode.sv ====
// D stage datapath: instruction register, register read and operand muxes
// Bypass and immediate selects come from proc_ctrl
`include "proc_params.svh"

module proc_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [31:0]              inst,
  input  logic                     en_d,
  input  logic [1:0]               byp0_sel,
  input  logic [1:0]               byp1_sel,
  input  logic                     op1_imm,
  input  logic [`PROC_XLEN-1:0]    ex_result,
  input  logic [`PROC_XLEN-1:0]    wb_result,
  input  logic [`PROC_XLEN-1:0]    mngr_in,
  input  logic [`PROC_XLEN-1:0]    rf_rdata0,
  input  logic [`PROC_XLEN-1:0]    rf_rdata1,
  output logic [`PROC_RADDR_W-1:0] rf_raddr0,
  output logic [`PROC_RADDR_W-1:0] rf_raddr1,
  output logic [31:0]              inst_d,
  output logic [`PROC_XLEN-1:0]    op0_d,
  output logic [`PROC_XLEN-1:0]    op1_d
);

  import proc_pkg::*;

  opcode_e               opcode_d;
  logic [`PROC_XLEN-1:0] imm_sext_d;
  logic [`PROC_XLEN-1:0] rs_val_d;
  logic [`PROC_XLEN-1:0] rt_val_d;

  // -------------------------------------------------------------------------
  // Instruction register
  // -------------------------------------------------------------------------

  // Loads only on a stream transfer, validity is tracked in proc_ctrl
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_d <= {OP_NOP, 28'd0};
    end else if (en_d) begin
      inst_d <= inst;
    end
  end

  // -------------------------------------------------------------------------
  // Unpack and register read
  // -------------------------------------------------------------------------

  assign opcode_d   = opcode_e'(inst_d[31:28]);
  assign rf_raddr0  = inst_d[24:22];
  assign rf_raddr1  = inst_d[21:19];
  assign imm_sext_d = {{(`PROC_XLEN-16){inst_d[15]}}, inst_d[15:0]};

  // -------------------------------------------------------------------------
  // Bypass and operand muxes
  // -------------------------------------------------------------------------

  always_comb begin
    case (byp0_sel)
      BYP_X:   rs_val_d = ex_result;
      BYP_W:   rs_val_d = wb_result;
      default: rs_val_d = rf_rdata0;
    endcase
    case (byp1_sel)
      BYP_X:   rt_val_d = ex_result;
      BYP_W:   rt_val_d = wb_result;
      default: rt_val_d = rf_rdata1;
    endcase
  end

  assign op0_d = rs_val_d;

  // MTX puts a copy of rs on operand 1 so ALU_CP1 carries it to W
  always_comb begin
    if (opcode_d == OP_MFX) begin
      op1_d = mngr_in;
    end else if (opcode_d == OP_MTX) begin
      op1_d = rs_val_d;
    end else if (op1_imm) begin
      op1_d = imm_sext_d;
    end else begin
      op1_d = rt_val_d;
    end
  end

endmodule

// ==== rtl/proc_execute.sv ====
// X stage datapath: operand registers and the ALU
// ex_result goes to the W register and back to the D bypass muxes
`include "proc_params.svh"

module proc_execute (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en_x,
  input  logic                  bubble_x,
  input  logic [`PROC_XLEN-1:0] op0_d,
  input  logic [`PROC_XLEN-1:0] op1_d,
  input  proc_pkg::alu_fn_e     alu_fn_x,
  output logic [`PROC_XLEN-1:0] ex_result
);

  import proc_pkg::*;

  logic [`PROC_XLEN-1:0] op0_x;
  logic [`PROC_XLEN-1:0] op1_x;
  logic                  slt_x;

  // A squashed slot carries zero operands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op0_x <= '0;
      op1_x <= '0;
    end else if (en_x) begin
      op0_x <= bubble_x ? '0 : op0_d;
      op1_x <= bubble_x ? '0 : op1_d;
    end
  end

  // Signed compare
  assign slt_x = $signed(op0_x) < $signed(op1_x);

  always_comb begin
    case (alu_fn_x)
      ALU_ADD: ex_result = op0_x + op1_x;
      ALU_SUB: ex_result = op0_x - op1_x;
      ALU_AND: ex_result = op0_x & op1_x;
      ALU_OR:  ex_result = op0_x | op1_x;
      ALU_XOR: ex_result = op0_x ^ op1_x;
      ALU_SLT: ex_result = {{(`PROC_XLEN-1){1'b0}}, slt_x};
      ALU_CP1: ex_result = op1_x;
      default: ex_result = op1_x;
    endcase
  end

endmodule

// ==== rtl/proc_params.svh ====
// Core-wide size defines for the pipelined integer core
// Include in any file that sizes data paths or register addresses
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data path width
`define PROC_XLEN 32

// Architectural register count and index width
`define PROC_NREGS 8
`define PROC_RADDR_W 3

`endif

// ==== rtl/proc_pkg.sv ====
// Shared types for the pipelined core
// Opcodes, ALU functions and bypass select codes, imported by the stages
package proc_pkg;

  // Instruction opcodes in bits 31:28
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLT  = 4'd6,
    OP_ADDI = 4'd7,
    OP_MFX  = 4'd8,
    OP_MTX  = 4'd9
  } opcode_e;

  // ALU functions in the X stage
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_CP1 = 3'd6
  } alu_fn_e;

  // Bypass mux selects for the D stage operands
  localparam logic [1:0] BYP_RF = 2'd0;
  localparam logic [1:0] BYP_X  = 2'd1;
  localparam logic [1:0] BYP_W  = 2'd2;

endpackage

// ==== rtl/proc_regfile.sv ====
// Register file, two combinational read ports and one write port
// Written from the W stage, read in the D stage
`include "proc_params.svh"

module proc_regfile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`PROC_RADDR_W-1:0] raddr0,
  output logic [`PROC_XLEN-1:0]    rdata0,
  input  logic [`PROC_RADDR_W-1:0] raddr1,
  output logic [`PROC_XLEN-1:0]    rdata1,
  input  logic                     wen,
  input  logic [`PROC_RADDR_W-1:0] waddr,
  input  logic [`PROC_XLEN-1:0]    wdata
);

  logic [`PROC_XLEN-1:0] regs [`PROC_NREGS];

  // All registers start at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `PROC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

endmodule

// ==== rtl/proc_result.sv ====
// W stage datapath: the writeback register
// Feeds the register file write port, the D bypass and the manager output
`include "proc_params.svh"

module proc_result (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en_w,
  input  logic [`PROC_XLEN-1:0] ex_result,
  output logic [`PROC_XLEN-1:0] wb_result,
  output logic [`PROC_XLEN-1:0] mngr_out
);

  logic [`PROC_XLEN-1:0] wb_result_w;

  // Holds while the pipeline is frozen on output back-pressure
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_result_w <= '0;
    end else if (en_w) begin
      wb_result_w <= ex_result;
    end
  end

  assign wb_result = wb_result_w;

  // MTX value reaches W through ALU_CP1, so the same register serves
  assign mngr_out = wb_result_w;

endmodule

// ==== rtl/proc_top.sv ====
// Top of the three-stage core: D, X and W datapath stages, control and
// register file, with instruction and manager valid/ready streams
`include "proc_params.svh"

module proc_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           inst,
  input  logic                  inst_val,
  output logic                  inst_rdy,
  input  logic [`PROC_XLEN-1:0] mngr_in,
  input  logic                  mngr_in_val,
  output logic                  mngr_in_rdy,
  output logic [`PROC_XLEN-1:0] mngr_out,
  output logic                  mngr_out_val,
  input  logic                  mngr_out_rdy
);

  import proc_pkg::*;

  logic                     en_d;
  logic                     en_x;
  logic                     en_w;
  logic                     bubble_x;
  logic [1:0]               byp0_sel;
  logic [1:0]               byp1_sel;
  logic                     op1_imm;
  alu_fn_e                  alu_fn_x;
  logic                     wen_w;
  logic [`PROC_RADDR_W-1:0] waddr_w;
  logic [31:0]              inst_d;
  logic [`PROC_RADDR_W-1:0] rf_raddr0;
  logic [`PROC_RADDR_W-1:0] rf_raddr1;
  logic [`PROC_XLEN-1:0]    rf_rdata0;
  logic [`PROC_XLEN-1:0]    rf_rdata1;
  logic [`PROC_XLEN-1:0]    op0_d;
  logic [`PROC_XLEN-1:0]    op1_d;
  logic [`PROC_XLEN-1:0]    ex_result;
  logic [`PROC_XLEN-1:0]    wb_result;

  // -------------------------------------------------------------------------
  // Control
  // -------------------------------------------------------------------------

  proc_ctrl ctrl0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_d       (inst_d),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy),
    .mngr_in_val  (mngr_in_val),
    .mngr_in_rdy  (mngr_in_rdy),
    .mngr_out_rdy (mngr_out_rdy),
    .mngr_out_val (mngr_out_val),
    .en_d         (en_d),
    .en_x         (en_x),
    .en_w         (en_w),
    .bubble_x     (bubble_x),
    .byp0_sel     (byp0_sel),
    .byp1_sel     (byp1_sel),
    .op1_imm      (op1_imm),
    .alu_fn_x     (alu_fn_x),
    .wen_w        (wen_w),
    .waddr_w      (waddr_w)
  );

  // -------------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------------

  proc_regfile rf0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (rf_raddr0),
    .rdata0 (rf_rdata0),
    .raddr1 (rf_raddr1),
    .rdata1 (rf_rdata1),
    .wen    (wen_w),
    .waddr  (waddr_w),
    .wdata  (wb_result)
  );

  proc_decode decode0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .en_d      (en_d),
    .byp0_sel  (byp0_sel),
    .byp1_sel  (byp1_sel),
    .op1_imm   (op1_imm),
    .ex_result (ex_result),
    .wb_result (wb_result),
    .mngr_in   (mngr_in),
    .rf_rdata0 (rf_rdata0),
    .rf_rdata1 (rf_rdata1),
    .rf_raddr0 (rf_raddr0),
    .rf_raddr1 (rf_raddr1),
    .inst_d    (inst_d),
    .op0_d     (op0_d),
    .op1_d     (op1_d)
  );

  proc_execute execute0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .en_x      (en_x),
    .bubble_x  (bubble_x),
    .op0_d     (op0_d),
    .op1_d     (op1_d),
    .alu_fn_x  (alu_fn_x),
    .ex_result (ex_result)
  );

  proc_result result0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .en_w      (en_w),
    .ex_result (ex_result),
    .wb_result (wb_result),
    .mngr_out  (mngr_out)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module proc_tb \
  -o proc_sim &&
./obj_dir/proc_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== test/proc_tb.sv ====
// Testbench for the three-stage core with random programs from an LFSR,
// an in-order reference model and a checker on the manager output stream
`include "proc_params.svh"

module proc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import proc_pkg::*;

  localparam int PROG_LEN    = 48;
  localparam int TOTAL_INSTS = `PROC_NREGS + 4 * PROG_LEN;
  localparam int STALL_BOUND = 24;
  localparam int DRAIN       = 8;
  localparam int WATCHDOG_NS = (TOTAL_INSTS * STALL_BOUND + 5 * (DRAIN + 4) + 10) * 10;

  logic                  clk;
  logic                  rst_n;
  logic [31:0]           inst;
  logic                  inst_val;
  logic                  inst_rdy;
  logic [`PROC_XLEN-1:0] mngr_in;
  logic                  mngr_in_val;
  logic                  mngr_in_rdy;
  logic [`PROC_XLEN-1:0] mngr_out;
  logic                  mngr_out_val;
  logic                  mngr_out_rdy;

  logic [15:0]           lfsr = 16'd9473;
  logic [`PROC_XLEN-1:0] model_regs [`PROC_NREGS];
  logic [31:0]           prog [$];
  logic [`PROC_XLEN-1:0] mngr_in_q [$];
  logic [`PROC_XLEN-1:0] exp_q [$];
  int                    hist0 = -1;
  int                    hist1 = -1;
  int                    n_mtx;
  int                    mtx_acc;
  int                    out_total;
  int                    err_count;
  int                    test_num;
  int                    pass_tests;
  int                    fail_tests;

  proc_tb_clk clk0 (
    .clk   (clk),
    .rst_n (rst_n)
  );

  proc_top dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy),
    .mngr_in      (mngr_in),
    .mngr_in_val  (mngr_in_val),
    .mngr_in_rdy  (mngr_in_rdy),
    .mngr_out     (mngr_out),
    .mngr_out_val (mngr_out_val),
    .mngr_out_rdy (mngr_out_rdy)
  );

  // -------------------------------------------------------------------------
  // Random source and checking
  // -------------------------------------------------------------------------

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  // Stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // -------------------------------------------------------------------------
  // Program generation with the reference model
  // -------------------------------------------------------------------------

  // Append one instruction and execute it on the model registers
  task automatic emit(input opcode_e op, input logic [2:0] rd, input logic [2:0] rs,
                      input logic [2:0] rt, input logic [15:0] imm);
    logic [`PROC_XLEN-1:0] a;
    logic [`PROC_XLEN-1:0] b;
    logic [`PROC_XLEN-1:0] v;
    bit                    writes;
    a = model_regs[rs];
    b = model_regs[rt];
    v = '0;
    writes = 1'b1;
    case (op)
      OP_ADD:  v = a + b;
      OP_SUB:  v = a - b;
      OP_AND:  v = a & b;
      OP_OR:   v = a | b;
      OP_XOR:  v = a ^ b;
      OP_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_ADDI: v = a + {{16{imm[15]}}, imm};
      OP_MFX: begin
        v = rand_bits(32);
        mngr_in_q.push_back(v);
      end
      OP_MTX: begin
        writes = 1'b0;
        exp_q.push_back(a);
        n_mtx++;
      end
      default: writes = 1'b0;
    endcase
    if (writes) begin
      model_regs[rd] = v;
    end
    prog.push_back({op, rd, rs, rt, 3'b000, imm});
    hist1 = hist0;
    hist0 = writes ? int'(rd) : -1;
  endtask

  // Source register tied to a recent destination or kept clear of both
  function automatic logic [2:0] pick_src(input bit dep, input bit near);
    logic [2:0] r;
    r = 3'(rand_bits(3));
    if (dep) begin
      if (near && hist0 >= 0) begin
        r = 3'(hist0);
      end else if (!near && hist1 >= 0) begin
        r = 3'(hist1);
      end
    end else begin
      while (int'(r) == hist0 || int'(r) == hist1) begin
        r = r + 3'd1;
      end
    end
    return r;
  endfunction

  task automatic gen_op(input bit dep);
    logic [2:0]  n;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic [15:0] imm;
    opcode_e     op;
    n   = 3'(rand_bits(3));
    op  = (n == 3'd7) ? OP_ADDI : opcode_e'(4'd1 + {1'b0, n});
    rd  = 3'(rand_bits(3));
    rs  = pick_src(dep, 1'b1);
    rt  = pick_src(dep, 1'b0);
    imm = 16'(rand_bits(16));
    emit(op, rd, rs, rt, imm);
  endtask

  task automatic gen_mtx(input bit dep);
    logic [2:0] rs;
    rs = pick_src(dep, 1'b1);
    emit(OP_MTX, 3'd0, rs, 3'd0, 16'd0);
  endtask

  task automatic gen_mfx();
    logic [2:0] rd;
    rd = 3'(rand_bits(3));
    emit(OP_MFX, rd, 3'd0, 3'd0, 16'd0);
  endtask

  // -------------------------------------------------------------------------
  // Stream driver and test wrapper
  // -------------------------------------------------------------------------

  // Drives on the rising edge and observes handshakes at the falling edge
  task automatic drive_program(input bit rand_in, input bit rand_out, output int n_out);
    int                    pc;
    int                    in_idx;
    int                    idle;
    bit                    inst_fire;
    bit                    in_fire;
    bit                    out_fire;
    logic [`PROC_XLEN-1:0] expv;
    pc = 0;
    in_idx = 0;
    idle = 0;
    n_out = 0;
    in_fire = 1'b0;
    while (idle < DRAIN) begin
      @(posedge clk);
      inst_val <= (pc < prog.size());
      inst     <= (pc < prog.size()) ? prog[pc] : '0;
      // A raised mngr_in_val stays up until taken
      if (in_fire || !mngr_in_val) begin
        mngr_in_val <= (in_idx < mngr_in_q.size()) && (!rand_in || rand_bits(1) != 0);
        mngr_in     <= (in_idx < mngr_in_q.size()) ? mngr_in_q[in_idx] : '0;
      end
      mngr_out_rdy <= !rand_out || (rand_bits(1) != 0);
      @(negedge clk);
      inst_fire = inst_val && inst_rdy;
      in_fire   = mngr_in_val && mngr_in_rdy;
      out_fire  = mngr_out_val && mngr_out_rdy;
      if (mngr_out_val && mtx_acc == out_total) begin
        err_count++;
        $display("mngr_out_val is high at %0d ns with no MTX in flight", $time);
      end
      if (out_fire) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("Extra output %h at %0d ns, no value was expected", mngr_out, $time);
        end else begin
          expv = exp_q.pop_front();
          check_value(mngr_out, expv, "mngr_out");
        end
        n_out++;
        out_total++;
      end
      if (inst_fire) begin
        if (prog[pc][31:28] == OP_MTX) begin
          mtx_acc++;
        end
        pc++;
      end
      if (in_fire) begin
        in_idx++;
      end
      if (pc == prog.size() && exp_q.size() == 0) begin
        idle++;
      end
    end
  endtask

  task automatic run_test(input string name, input bit rand_in, input bit rand_out);
    int errs_before;
    int n_out;
    errs_before = err_count;
    drive_program(rand_in, rand_out, n_out);
    check_value(32'(n_out), 32'(n_mtx), "output count");
    test_num++;
    if (err_count == errs_before) begin
      pass_tests++;
      $display("Test %0d %s: passed, %0d outputs", test_num, name, n_out);
    end else begin
      fail_tests++;
      $display("Test %0d %s: failed, %0d errors", test_num, name, err_count - errs_before);
    end
    prog.delete();
    mngr_in_q.delete();
    exp_q.delete();
    n_mtx = 0;
    hist0 = -1;
    hist1 = -1;
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------

  initial begin
    logic [2:0] kind;
    inst         <= '0;
    inst_val     <= 1'b0;
    mngr_in      <= '0;
    mngr_in_val  <= 1'b0;
    mngr_out_rdy <= 1'b0;
    for (int r = 0; r < `PROC_NREGS; r++) begin
      model_regs[r] = '0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value(32'(inst_rdy), 32'd1, "inst_rdy after reset");
    check_value(32'(mngr_out_val), 32'd0, "mngr_out_val after reset");
    check_value(32'(mngr_in_rdy), 32'd0, "mngr_in_rdy after reset");

    // Registers read back as zero straight out of reset
    for (int r = 0; r < `PROC_NREGS; r++) begin
      emit(OP_MTX, 3'd0, 3'(r), 3'd0, 16'd0);
    end
    run_test("reset_zero", 1'b0, 1'b0);

    while (prog.size() < PROG_LEN) begin
      if (prog.size() % 3 == 2) begin
        gen_mtx(1'b0);
      end else begin
        gen_op(1'b0);
      end
    end
    run_test("independent_alu", 1'b0, 1'b0);

    // Sources taken from the X and W destinations
    while (prog.size() < PROG_LEN) begin
      if (prog.size() % 4 == 3) begin
        gen_mtx(1'b1);
      end else begin
        gen_op(1'b1);
      end
    end
    run_test("dependent_chains", 1'b0, 1'b0);

    while (prog.size() < PROG_LEN) begin
      gen_mfx();
      gen_op(1'b1);
      gen_mtx(1'b1);
    end
    run_test("mfx_stream", 1'b1, 1'b0);

    while (prog.size() < PROG_LEN) begin
      kind = 3'(rand_bits(3));
      if (kind < 3'd3) begin
        gen_mtx(rand_bits(1) != 0);
      end else if (kind == 3'd3) begin
        gen_mfx();
      end else begin
        gen_op(rand_bits(1) != 0);
      end
    end
    run_test("out_backpressure", 1'b1, 1'b1);

    $display("%0d tests passed, %0d failed, %0d errors", pass_tests, fail_tests, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Bound on the whole run from the instruction count and the stall allowance
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog timeout: tests still running after %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== test/proc_tb_clk.sv ====
// Clock and reset source for the core testbench
// 10 ns clock, active-low reset released on the third rising edge
module proc_tb_clk (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
